// ==== verilog/armCtrlPkg.sv ====
package armCtrlPkg;

  // ==============================
  // Widths
  // ==============================
  localparam int instrWidth   = 32;
  localparam int flagWidth    = 4;                  // NZCV
  localparam int aluCtrlWidth = 4;

  // ALU opcodes, same encoding as the DP opcode field
  localparam logic [3:0] aluAdd = 4'b0100;
  localparam logic [3:0] aluSub = 4'b0010;
  localparam logic [3:0] aluMov = 4'b1101;

  // Instruction class, bits 27:26
  localparam logic [1:0] opDataProc = 2'b00;
  localparam logic [1:0] opMem      = 2'b01;
  localparam logic [1:0] opBranch   = 2'b10;

  localparam logic [3:0] regPc = 4'd15;

  // ==============================
  // Condition codes
  // ==============================
  localparam logic [3:0] condEq = 4'h0;
  localparam logic [3:0] condNe = 4'h1;
  localparam logic [3:0] condCs = 4'h2;
  localparam logic [3:0] condCc = 4'h3;
  localparam logic [3:0] condMi = 4'h4;
  localparam logic [3:0] condPl = 4'h5;
  localparam logic [3:0] condVs = 4'h6;
  localparam logic [3:0] condVc = 4'h7;
  localparam logic [3:0] condHi = 4'h8;
  localparam logic [3:0] condLs = 4'h9;
  localparam logic [3:0] condGe = 4'hA;
  localparam logic [3:0] condLt = 4'hB;
  localparam logic [3:0] condGt = 4'hC;
  localparam logic [3:0] condLe = 4'hD;
  localparam logic [3:0] condAl = 4'hE;

  // Bit positions in the flags nibble
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  // One instruction word, read as data processing or as single load/store
  typedef union packed {
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic        imm;                                // Immediate operand2
      logic [3:0]  opcode;
      logic        sBit;                               // Set flags
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] operand2;
    } dp;
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic        regOffset;                          // Register offset, not imm12
      logic        preIndex;
      logic        up;                                 // Add offset
      logic        byteAcc;                            // Byte, not word
      logic        writeBack;
      logic        load;
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] offset12;
    } mem;
  } instrWordT;

endpackage

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
  input  logic [armCtrlPkg::instrWidth-1:0]   instrD,
  output logic [1:0]                          regSrcD,      // Bit 1 store data reg, bit 0 PC as Rn
  output logic [1:0]                          immSrcD,      // 00 imm8, 01 imm12, 10 imm24
  output logic                                aluSrcD,      // Immediate as operand B
  output logic                                memtoRegD,
  output logic                                regWriteD,
  output logic                                memWriteD,
  output logic                                branchD,
  output logic                                byteD,
  output logic [armCtrlPkg::aluCtrlWidth-1:0] aluControlD,
  output logic [1:0]                          flagWriteD,   // {NZ, CV}
  output logic                                pcSrcD
);

  armCtrlPkg::instrWordT instr;
  logic [8:0]            controlsD;
  logic                  isTestOp;

  assign instr = instrD;

  // TST TEQ CMP CMN only touch flags
  assign isTestOp = (instr.dp.opcode[3:2] == 2'b10);

  // ==============================
  // Main decode
  // ==============================
  // {regSrc, immSrc, aluSrc, memtoReg, regWrite, memWrite, branch}
  always_comb begin
    controlsD = 9'b0;                                   // Unsupported class, no writes
    case (instr.dp.op)
      armCtrlPkg::opDataProc: begin
        controlsD = {2'b00, 2'b00, instr.dp.imm, 1'b0, ~isTestOp, 1'b0, 1'b0};
      end
      armCtrlPkg::opMem: begin
        if (instr.mem.load) begin                       // LDR / LDRB
          controlsD = {2'b00, 2'b01, ~instr.mem.regOffset, 1'b1, 1'b1, 1'b0, 1'b0};
        end else begin                                  // STR / STRB, Rd read as data
          controlsD = {2'b10, 2'b01, ~instr.mem.regOffset, 1'b0, 1'b0, 1'b1, 1'b0};
        end
      end
      armCtrlPkg::opBranch: begin                       // PC + imm24
        controlsD = {2'b01, 2'b10, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1};
      end
      default: begin
        controlsD = 9'b0;
      end
    endcase
  end

  assign {regSrcD, immSrcD, aluSrcD, memtoRegD, regWriteD, memWriteD, branchD} = controlsD;

  // ==============================
  // ALU control
  // ==============================
  always_comb begin
    flagWriteD = 2'b00;                                 // Only S-bit DP sets flags
    case (instr.dp.op)
      armCtrlPkg::opDataProc: begin
        aluControlD = instr.dp.opcode;                  // Opcode passes straight through
        flagWriteD  = {2{instr.dp.sBit}};
      end
      armCtrlPkg::opMem: begin
        // Base plus or minus offset
        aluControlD = instr.mem.up ? armCtrlPkg::aluAdd : armCtrlPkg::aluSub;
      end
      armCtrlPkg::opBranch: begin
        aluControlD = armCtrlPkg::aluAdd;               // Branch target
      end
      default: begin
        aluControlD = armCtrlPkg::aluMov;               // Harmless pass of operand B
      end
    endcase
  end

  // Byte access only means something for load/store
  assign byteD = (instr.mem.op == armCtrlPkg::opMem) & instr.mem.byteAcc;

  // PC changes on a write to R15 or any branch
  assign pcSrcD = (regWriteD & (instr.dp.rd == armCtrlPkg::regPc)) | branchD;

endmodule

// ==== verilog/pipelineControl.sv ====
`timescale 1ns/1ps

module pipelineControl (
  input  logic                                clk, rstN,
  // Decode control word
  input  logic                                aluSrcD, memtoRegD, regWriteD, memWriteD,
  input  logic                                branchD, byteD, pcSrcD,
  input  logic [armCtrlPkg::aluCtrlWidth-1:0] aluControlD,
  input  logic [1:0]                          flagWriteD,
  input  logic [armCtrlPkg::instrWidth-1:0]   instrD,
  // From condition unit and byte mask
  input  logic                                condExE,
  input  logic [armCtrlPkg::flagWidth-1:0]    flagsE,
  input  logic [3:0]                          byteMaskE,
  input  logic [1:0]                          byteOffsetE,
  // Hazard unit
  input  logic                                stallE, flushE, stallM, flushM, stallW, flushW,
  input  logic [armCtrlPkg::flagWidth-1:0]    aluFlagsE,
  // Execute
  output logic                                aluSrcE,
  output logic [armCtrlPkg::aluCtrlWidth-1:0] aluControlE,
  output logic [3:0]                          condE,
  output logic [1:0]                          flagWriteE,
  output logic                                branchTakenE, byteE, storeE,
  // Memory
  output logic                                memWriteM,
  output logic [3:0]                          byteMaskM,
  output logic                                setFlagsM,
  output logic [armCtrlPkg::flagWidth-1:0]    flagsNextM,
  // Writeback
  output logic                                memtoRegW, regWriteW, pcSrcW,
  output logic [1:0]                          byteOffsetW,
  output logic                                loadByteW, setFlagsW,
  output logic [armCtrlPkg::flagWidth-1:0]    flagsNextW
);

  armCtrlPkg::instrWordT                 instr;
  logic [11:0]                           ctrlD, ctrlE;
  logic                                  branchE, memtoRegE, regWriteE, memWriteE, pcSrcE;
  logic                                  setFlagsE;
  logic [armCtrlPkg::flagWidth-1:0]      flagsNextE;
  logic [9:0]                            ctrlMIn, ctrlM;
  logic                                  memtoRegM, regWriteM, pcSrcM, byteM;
  logic [1:0]                            byteOffsetM;
  logic [4:0]                            ctrlWIn, ctrlW;

  assign instr = instrD;

  // ==============================
  // Decode to Execute
  // ==============================
  assign ctrlD = {instr.dp.cond, flagWriteD, branchD, byteD,
                  memtoRegD, regWriteD, memWriteD, pcSrcD};
  assign {condE, flagWriteE, branchE, byteE, memtoRegE, regWriteE, memWriteE, pcSrcE} = ctrlE;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ctrlE <= '0;
    end else if (flushE) begin
      ctrlE <= '0;                                      // Bubble, flush beats stall
    end else if (!stallE) begin
      ctrlE <= ctrlD;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallE) begin
      aluSrcE     <= aluSrcD;                           // Datapath selects only
      aluControlE <= aluControlD;
    end
  end

  // Condition gating, a failed instruction leaves nothing behind
  assign branchTakenE = branchE & condExE;
  assign storeE       = memWriteE & condExE;
  assign setFlagsE    = (|flagWriteE) & condExE;

  // NZ and CV groups come from the ALU only when enabled
  always_comb begin
    flagsNextE = flagsE;
    if (flagWriteE[1]) begin
      flagsNextE[armCtrlPkg::flagN] = aluFlagsE[armCtrlPkg::flagN];
      flagsNextE[armCtrlPkg::flagZ] = aluFlagsE[armCtrlPkg::flagZ];
    end
    if (flagWriteE[0]) begin
      flagsNextE[armCtrlPkg::flagC] = aluFlagsE[armCtrlPkg::flagC];
      flagsNextE[armCtrlPkg::flagV] = aluFlagsE[armCtrlPkg::flagV];
    end
  end

  // ==============================
  // Execute to Memory
  // ==============================
  assign ctrlMIn = {storeE, memtoRegE & condExE, regWriteE & condExE, pcSrcE & condExE,
                    setFlagsE, byteE, byteMaskE};
  assign {memWriteM, memtoRegM, regWriteM, pcSrcM, setFlagsM, byteM, byteMaskM} = ctrlM;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ctrlM <= '0;
    end else if (flushM) begin
      ctrlM <= '0;
    end else if (!stallM) begin
      ctrlM <= ctrlMIn;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallM) begin
      byteOffsetM <= byteOffsetE;
      flagsNextM  <= flagsNextE;
    end
  end

  // ==============================
  // Memory to Writeback
  // ==============================
  assign ctrlWIn = {memtoRegM, regWriteM, pcSrcM, setFlagsM, byteM & memtoRegM}; // LDRB only
  assign {memtoRegW, regWriteW, pcSrcW, setFlagsW, loadByteW} = ctrlW;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ctrlW <= '0;
    end else if (flushW) begin
      ctrlW <= '0;
    end else if (!stallW) begin
      ctrlW <= ctrlWIn;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallW) begin
      byteOffsetW <= byteOffsetM;                       // Lane select for load data
      flagsNextW  <= flagsNextM;
    end
  end

endmodule

// ==== verilog/condUnit.sv ====
`timescale 1ns/1ps

module condUnit (
  input  logic                             clk, rstN,
  input  logic [3:0]                       condE,        // Cond field of Execute instr
  input  logic                             setFlagsM,
  input  logic [armCtrlPkg::flagWidth-1:0] flagsNextM,
  input  logic                             setFlagsW,
  input  logic [armCtrlPkg::flagWidth-1:0] flagsNextW,
  input  logic                             stallW,
  output logic                             condExE,
  output logic [armCtrlPkg::flagWidth-1:0] flagsE,       // Flags seen by Execute
  output logic [armCtrlPkg::flagWidth-1:0] flagsW        // Architectural NZCV
);

  logic neg, zero, carry, ovf;

  // ==============================
  // Flag forwarding
  // ==============================
  // Youngest producer wins
  always_comb begin
    if (setFlagsM) begin
      flagsE = flagsNextM;
    end else if (setFlagsW) begin
      flagsE = flagsNextW;                              // Register not written yet
    end else begin
      flagsE = flagsW;
    end
  end

  assign neg   = flagsE[armCtrlPkg::flagN];
  assign zero  = flagsE[armCtrlPkg::flagZ];
  assign carry = flagsE[armCtrlPkg::flagC];
  assign ovf   = flagsE[armCtrlPkg::flagV];

  // ==============================
  // Condition table
  // ==============================
  always_comb begin
    case (condE)
      armCtrlPkg::condEq: condExE = zero;
      armCtrlPkg::condNe: condExE = ~zero;
      armCtrlPkg::condCs: condExE = carry;
      armCtrlPkg::condCc: condExE = ~carry;
      armCtrlPkg::condMi: condExE = neg;
      armCtrlPkg::condPl: condExE = ~neg;
      armCtrlPkg::condVs: condExE = ovf;
      armCtrlPkg::condVc: condExE = ~ovf;
      armCtrlPkg::condHi: condExE = carry & ~zero;      // Unsigned higher
      armCtrlPkg::condLs: condExE = ~carry | zero;
      armCtrlPkg::condGe: condExE = (neg == ovf);       // Signed compares
      armCtrlPkg::condLt: condExE = (neg != ovf);
      armCtrlPkg::condGt: condExE = ~zero & (neg == ovf);
      armCtrlPkg::condLe: condExE = zero | (neg != ovf);
      armCtrlPkg::condAl: condExE = 1'b1;
      default:            condExE = 1'b0;               // 1111 never executes here
    endcase
  end

  // Flags register, written as the S-bit instr leaves Writeback
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flagsW <= '0;
    end else if (setFlagsW && !stallW) begin
      flagsW <= flagsNextW;
    end
  end

endmodule

// ==== verilog/byteMask.sv ====
`timescale 1ns/1ps

module byteMask (
  input  logic       byteE,          // STRB, not STR
  input  logic       storeE,         // Store that passed its condition
  input  logic [1:0] aluResultLowE,  // Address bits 1:0
  output logic [3:0] byteMaskE,      // One bit per byte lane
  output logic [1:0] byteOffsetE     // Lane of a byte load
);

  // ==============================
  // Write lanes
  // ==============================
  always_comb begin
    if (!storeE) begin
      byteMaskE = 4'b0000;                               // Loads and ALU ops write nothing
    end else if (byteE) begin
      byteMaskE = 4'b0001 << aluResultLowE;              // Single addressed lane
    end else begin
      byteMaskE = 4'b1111;                               // Full word
    end
  end

  // Little endian, lane equals the address low bits
  // Word accesses ignore it downstream
  assign byteOffsetE = byteE ? aluResultLowE : 2'b00;

endmodule

// ==== verilog/armController.sv ====
`timescale 1ns/1ps

module armController (
  input  logic                                clk, rstN,
  input  logic [armCtrlPkg::instrWidth-1:0]   instrD,
  input  logic [armCtrlPkg::flagWidth-1:0]    aluFlagsE,      // Raw ALU flags in Execute
  input  logic [1:0]                          aluResultLowE,  // Address bits 1:0
  input  logic                                stallE, flushE,
  input  logic                                stallM, flushM,
  input  logic                                stallW, flushW,
  output logic [1:0]                          regSrcD, immSrcD,
  output logic                                aluSrcE,
  output logic [armCtrlPkg::aluCtrlWidth-1:0] aluControlE,
  output logic                                branchTakenE,
  output logic                                memWriteM,
  output logic [3:0]                          byteMaskM,
  output logic                                memtoRegW, regWriteW, pcSrcW,
  output logic [1:0]                          byteOffsetW,
  output logic                                loadByteW,
  output logic [armCtrlPkg::flagWidth-1:0]    flagsW
);

  // Decode control word
  logic                                aluSrcD, memtoRegD, regWriteD, memWriteD;
  logic                                branchD, byteD, pcSrcD;
  logic [armCtrlPkg::aluCtrlWidth-1:0] aluControlD;
  logic [1:0]                          flagWriteD;
  // Execute side
  logic [3:0]                          condE;
  logic                                condExE, byteE, storeE;
  logic [armCtrlPkg::flagWidth-1:0]    flagsE;         // Forwarded flags
  logic [3:0]                          byteMaskE;
  logic [1:0]                          byteOffsetE;
  // Flag pipeline
  logic                                setFlagsM, setFlagsW;
  logic [armCtrlPkg::flagWidth-1:0]    flagsNextM, flagsNextW;

  instrDecoder iDecoder (
    .instrD, .regSrcD, .immSrcD, .aluSrcD, .memtoRegD, .regWriteD, .memWriteD,
    .branchD, .byteD, .aluControlD, .flagWriteD, .pcSrcD
  );

  pipelineControl iPipe (
    .clk, .rstN, .aluSrcD, .memtoRegD, .regWriteD, .memWriteD, .branchD, .byteD,
    .aluControlD, .flagWriteD, .pcSrcD, .instrD, .condExE, .flagsE, .byteMaskE,
    .byteOffsetE, .stallE, .flushE, .stallM, .flushM, .stallW, .flushW, .aluFlagsE,
    .aluSrcE, .aluControlE, .condE, .flagWriteE (), .branchTakenE, .byteE, .storeE,
    .memWriteM, .byteMaskM, .setFlagsM, .flagsNextM, .memtoRegW, .regWriteW, .pcSrcW,
    .byteOffsetW, .loadByteW, .setFlagsW, .flagsNextW
  );

  condUnit iCond (
    .clk, .rstN, .condE, .setFlagsM, .flagsNextM, .setFlagsW, .flagsNextW, .stallW,
    .condExE, .flagsE, .flagsW
  );

  byteMask iByteMask (
    .byteE, .storeE, .aluResultLowE, .byteMaskE, .byteOffsetE
  );

endmodule

// ==== testbench/armControllerTb.sv ====
`timescale 1ns/1ps

module armControllerTb;

  localparam int          edgeLimit = 8;             // Clock toggles allowed per wait
  localparam logic [31:0] nopInstr  = 32'hF000_0000; // Cond 1111 never executes

  logic        clk, rstN;
  logic [31:0] instrD;
  logic [3:0]  aluFlagsE;
  logic [1:0]  aluResultLowE;
  logic        stallE, flushE, stallM, flushM, stallW, flushW;
  logic [1:0]  regSrcD, immSrcD, byteOffsetW;
  logic        aluSrcE, branchTakenE, memWriteM, memtoRegW, regWriteW, pcSrcW, loadByteW;
  logic [3:0]  aluControlE, byteMaskM, flagsW;

  // One row of the data file
  logic [8*16-1:0]  testName;
  logic [8*200-1:0] lineBuf;
  logic [31:0]      instr, flagsIn, lowIn, flushMask, followInstr;
  logic [31:0]      expRegSrc, expImmSrc, expAluCtrl, expTaken, expFollowTaken;
  logic [31:0]      expMemWrite, expMask, expRegWrite, expPcSrc, expFlags;
  int               fd, fields, errCount, errAtStart, testCount, failCount;

  armController i_armController (
    .clk, .rstN, .instrD, .aluFlagsE, .aluResultLowE, .stallE, .flushE, .stallM, .flushM,
    .stallW, .flushW, .regSrcD, .immSrcD, .aluSrcE, .aluControlE, .branchTakenE,
    .memWriteM, .byteMaskM, .memtoRegW, .regWriteW, .pcSrcW, .byteOffsetW, .loadByteW,
    .flagsW
  );

  always #10 clk = ~clk;                              // 20 ns period

  // ==============================
  // Helpers
  // ==============================
  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $finish;
  endtask

  // Level 1 returns on a rising edge and level 0 on a falling edge
  task automatic clockEdge(input logic level);
    int toggles;
    toggles = 0;
    do begin
      @(clk);
      toggles++;
    end while (clk !== level && toggles < edgeLimit);
    if (clk !== level) begin
      abortRun("Timed out waiting for a clock edge, the clock is not toggling");
    end
  endtask

  task automatic checkField(input string field, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("MISMATCH %0s %s expected %0h actual %0h", testName, field, expected, actual);
      errCount++;
    end
  endtask

  // Operand B is an immediate for DP with I set, for imm12 load/store and for branches
  function automatic logic immOperand(input logic [31:0] word);
    case (word[27:26])
      2'b00:   return word[25];
      2'b01:   return ~word[25];                      // I set means register offset
      2'b10:   return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic reportTest();
    testCount++;
    if (errCount == errAtStart) begin
      $display("test %0s ok", testName);
    end else begin
      $display("test %0s failed", testName);
      failCount++;
    end
  endtask

  // Main instr runs from D to W and its follower is decoded for two slots behind it
  task automatic runTest();
    logic isMemOp, isLoad, isByte;
    isMemOp    = (instr[27:26] == 2'b01);
    isLoad     = isMemOp & instr[20];                 // L bit
    isByte     = isMemOp & instr[22];                 // B bit
    errAtStart = errCount;
    clockEdge(1'b1);
    instrD        <= instr;
    aluFlagsE     <= flagsIn[3:0];                    // Held while the instr is in Execute
    aluResultLowE <= lowIn[1:0];
    flushE        <= flushMask[0];                    // Taken at the edge into Execute
    clockEdge(1'b0);
    checkField("regSrcD", expRegSrc, regSrcD);
    checkField("immSrcD", expImmSrc, immSrcD);
    checkField("flagsW", expFlags, flagsW);           // Left by earlier rows
    clockEdge(1'b1);
    instrD <= followInstr;
    flushE <= 1'b0;
    flushM <= flushMask[1];
    clockEdge(1'b0);
    checkField("aluControlE", expAluCtrl, aluControlE);
    checkField("aluSrcE", immOperand(instr), aluSrcE);
    checkField("branchTakenE", expTaken, branchTakenE);
    clockEdge(1'b1);
    flushM <= 1'b0;                                   // Follower stays in Decode for a second copy
    flushW <= flushMask[2];
    clockEdge(1'b0);
    checkField("memWriteM", expMemWrite, memWriteM);
    checkField("byteMaskM", expMask, byteMaskM);
    checkField("followTakenE", expFollowTaken, branchTakenE); // Flags forwarded from Memory
    clockEdge(1'b1);
    instrD <= nopInstr;
    flushW <= 1'b0;
    clockEdge(1'b0);
    checkField("regWriteW", expRegWrite, regWriteW);
    checkField("pcSrcW", expPcSrc, pcSrcW);
    checkField("memtoRegW", expRegWrite[0] & isLoad, memtoRegW); // Only a load that wrote
    checkField("loadByteW", expRegWrite[0] & isLoad & isByte, loadByteW);
    checkField("byteOffsetW", isByte ? {30'b0, lowIn[1:0]} : 32'h0, byteOffsetW);
    checkField("followTakenW", expFollowTaken, branchTakenE); // Second copy sees Writeback flags
    reportTest();
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    clk           = 1'b0;
    rstN          = 1'b0;
    instrD        = nopInstr;
    aluFlagsE     = 4'h0;
    aluResultLowE = 2'b00;
    {stallE, flushE, stallM, flushM, stallW, flushW} = 6'b0;
    errCount  = 0;
    testCount = 0;
    failCount = 0;

    // Two edges under reset
    clockEdge(1'b1);
    clockEdge(1'b1);
    rstN <= 1'b1;
    clockEdge(1'b0);
    testName   = "reset";
    errAtStart = errCount;
    checkField("branchTakenE", 32'h0, branchTakenE);
    checkField("memWriteM", 32'h0, memWriteM);
    checkField("byteMaskM", 32'h0, byteMaskM);
    checkField("memtoRegW", 32'h0, memtoRegW);
    checkField("regWriteW", 32'h0, regWriteW);
    checkField("pcSrcW", 32'h0, pcSrcW);
    checkField("flagsW", 32'h0, flagsW);
    reportTest();

    fd = $fopen("testbench/controllerTestdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open testbench/controllerTestdata.txt for reading");
      errCount++;
    end else begin
      while ($fgets(lineBuf, fd) != 0) begin
        fields = $sscanf(lineBuf, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         testName, instr, flagsIn, lowIn, flushMask, followInstr,
                         expRegSrc, expImmSrc, expAluCtrl, expTaken, expFollowTaken,
                         expMemWrite, expMask, expRegWrite, expPcSrc, expFlags);
        if (fields == 16) begin                       // Comment and blank lines fall out here
          runTest();
        end
      end
      $fclose(fd);
    end
    if (testCount < 2) begin
      $display("No test rows were read from the data file");
      errCount++;
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             testCount, testCount - failCount, failCount, errCount);
    if (errCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== armController.f ====
verilog/armCtrlPkg.sv
verilog/instrDecoder.sv
verilog/pipelineControl.sv
verilog/condUnit.sv
verilog/byteMask.sv
verilog/armController.sv
testbench/armControllerTb.sv

// ==== testbench/controllerTestdata.txt ====
# name instr aluFlagsE addrLow flushMask(W,M,E) followInstr, all hex
# expected: regSrcD immSrcD aluControlE taken followTaken memWriteM byteMaskM regWriteW pcSrcW flagsW
addImm     E2821005 0 0 0 F0000000  0 0 4 0 0 0 0 1 0 0
subReg     E0443005 0 0 0 F0000000  0 0 2 0 0 0 0 1 0 0
ldrUp      E5921004 0 0 0 F0000000  0 1 4 0 0 0 0 1 0 0
strDown    E5021004 0 0 0 F0000000  2 1 2 0 0 1 F 0 0 0
strbLane1  E5C21001 0 1 0 F0000000  2 1 4 0 0 1 2 0 0 0
strbLane2  E5C21002 0 2 0 F0000000  2 1 4 0 0 1 4 0 0 0
strbLane3  E5C21003 0 3 0 F0000000  2 1 4 0 0 1 8 0 0 0
branchAl   EA000010 0 0 0 F0000000  1 2 4 1 0 0 0 0 1 0
beqFail    0A000010 0 0 0 F0000000  1 2 4 0 0 0 0 0 0 0
movPc      E1A0F001 0 0 0 F0000000  0 0 D 0 0 0 0 1 1 0
addsZero   E2921001 4 0 0 0A000010  0 0 4 0 1 0 0 1 0 0
beqTaken   0A000010 0 0 0 F0000000  1 2 4 1 0 0 0 0 1 4
strNeFail  15021004 0 0 0 F0000000  2 1 2 0 0 0 0 0 0 4
subsNeg    E2521001 8 0 0 4A000010  0 0 2 0 1 0 0 1 0 4
cmpCarry   E3520001 2 0 0 8A000010  0 0 A 0 1 0 0 0 0 8
bgeTaken   AA000010 0 0 0 F0000000  1 2 4 1 0 0 0 0 1 2
flushEMov  E1A0F001 0 0 1 F0000000  0 0 D 0 0 0 0 0 0 2
flushEBr   EA000010 0 0 1 F0000000  1 2 4 0 0 0 0 0 0 2
flushMStr  E5021004 0 0 2 F0000000  2 1 2 0 0 0 0 0 0 2
flushWAdd  E2821005 0 0 4 F0000000  0 0 4 0 0 0 0 0 0 2
